/* rtl/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode (
	input  logic              clk24mhz,
	input  logic              rst_i,
	input  bus_pkg::bus_req_t req_i,
	input  logic              done_i,
	output bus_pkg::bus_req_t dec_req_o,
	output map_pkg::slave_e   dec_slave_o,
	output logic              busy_o
);
	import bus_pkg::*;
	import map_pkg::*;

	logic   strobe;
	slave_e slave_w;
	waddr_t base_w;

	// Region base as a word address
	function automatic waddr_t region_wbase(slave_e s);
		mapsz_t base;
		base = region_base(s);
		return base[$bits(mapsz_t)-1:2];
	endfunction

	assign strobe = (req_i.op != NONE);

	// Walk down so that the lowest region holding the address wins
	always_comb begin
		slave_w = INVALID;
		base_w  = region_wbase(INVALID);
		for (int k = int'(BOOTLDR); k >= 0; k--) begin
			if (req_i.addr < region_wbase(slave_e'(k + 1))) begin
				slave_w = slave_e'(k);
				base_w  = region_wbase(slave_e'(k));
			end
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (strobe) begin
			dec_req_o.addr <= req_i.addr - base_w;
			dec_req_o.data <= req_i.data;
			dec_slave_o    <= slave_w;
		end
		if (rst_i) begin
			dec_req_o.op <= NONE;
			busy_o       <= 1'b0;
		end else begin
			// Op falls back to NONE with the strobe
			dec_req_o.op <= req_i.op;
			if (strobe) begin
				busy_o <= 1'b1;
			end else if (done_i) begin
				busy_o <= 1'b0;
			end
		end
	end

	// One access at a time, the next strobe waits for the response
	a_no_strobe_when_busy: assert property (
		@(posedge clk24mhz) disable iff (rst_i)
		strobe |-> !busy_o
	);

endmodule

/* rtl/bus_pkg.sv */
`include "sysctl_settings.svh"

package bus_pkg;

	// Data word and byte enables
	typedef logic [`SYSCTL_ARCHBITSZ-1:0] word_t;
	typedef logic [`SYSCTL_SELBITSZ-1:0]  sel_t;

	// Word address, the byte address without its low bits
	typedef logic [`SYSCTL_ADDRBITSZ-1:0] waddr_t;

	// Access kind, SWAP writes and returns the old word
	typedef enum logic [1:0] {
		NONE  = 2'd0,
		WRITE = 2'd1,
		READ  = 2'd2,
		SWAP  = 2'd3
	} bus_op_e;

	// One access, held for a single cycle
	typedef struct packed {
		bus_op_e op;
		waddr_t  addr;
		word_t   data;
	} bus_req_t;

	// Reply, data is valid only with rdy
	typedef struct packed {
		word_t data;
		logic  rdy;
	} bus_rsp_t;

endpackage

/* rtl/bus_result.sv */
`timescale 1ns/1ps

module bus_result (
	input  logic              clk24mhz,
	input  logic              rst_i,
	input  bus_pkg::bus_req_t dec_req_i,
	input  map_pkg::slave_e   dec_slave_i,
	input  bus_pkg::bus_rsp_t tbl_rsp_i,
	input  bus_pkg::bus_rsp_t ext_rsp_i,
	output bus_pkg::bus_req_t ext_req_o,
	output map_pkg::slave_e   ext_slave_o,
	output bus_pkg::bus_rsp_t rsp_o,
	output logic              done_o
);
	import bus_pkg::*;
	import map_pkg::*;

	typedef enum logic {
		IDLE,
		WAIT_EXT
	} state_e;

	state_e state;
	logic   ext_hit;

	// Everything except the table and the invalid device lives outside
	assign ext_hit = (state == IDLE) && (dec_req_i.op != NONE) &&
		!(dec_slave_i inside {DEVTBL, INVALID});

	always_comb begin
		ext_req_o = dec_req_i;
		if (!ext_hit) begin
			ext_req_o.op = NONE;
		end
	end

	assign ext_slave_o = dec_slave_i;

	// The one response for the access in flight
	assign done_o = ((state == IDLE) && tbl_rsp_i.rdy) ||
		((state == WAIT_EXT) && ext_rsp_i.rdy);

	always_ff @(posedge clk24mhz) begin
		if (rst_i) begin
			state <= IDLE;
		end else if (ext_hit) begin
			state <= WAIT_EXT;
		end else if ((state == WAIT_EXT) && ext_rsp_i.rdy) begin
			state <= IDLE;
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (done_o) begin
			rsp_o.data <= (state == WAIT_EXT) ? ext_rsp_i.data : tbl_rsp_i.data;
		end
		if (rst_i) begin
			rsp_o.rdy <= 1'b0;
		end else begin
			rsp_o.rdy <= done_o;
		end
	end

	// External replies only come back for a forwarded access
	a_no_ext_rsp_idle: assert property (
		@(posedge clk24mhz) disable iff (rst_i)
		(state == IDLE) |-> !ext_rsp_i.rdy
	);

endmodule

/* rtl/devtbl_exec.sv */
`timescale 1ns/1ps
`include "sysctl_settings.svh"

module devtbl_exec (
	input  logic              clk24mhz,
	input  logic              rst_i,
	input  bus_pkg::bus_req_t dec_req_i,
	input  map_pkg::slave_e   dec_slave_i,
	input  bus_pkg::sel_t     sel_i,
	output bus_pkg::bus_rsp_t tbl_rsp_o,
	output map_pkg::rst_cmd_t rst_cmd_o
);
	import bus_pkg::*;
	import map_pkg::*;

	sel_t       sel_q;
	dev_entry_t entry;
	word_t      rd_data;
	logic       tbl_hit;
	logic       cmd_hit;
	logic       cmd_wr;

	// Byte enables arrive with the strobe, one cycle ahead of the decoded access
	always_ff @(posedge clk24mhz) begin
		sel_q <= sel_i;
	end

	assign tbl_hit = (dec_req_i.op != NONE) && (dec_slave_i == DEVTBL);
	assign cmd_hit = (dec_req_i.addr == waddr_t'(`SYSCTL_RSTCMD_WORD));
	assign cmd_wr  = tbl_hit && cmd_hit && (dec_req_i.op inside {WRITE, SWAP}) && sel_q[0];

	// Even word is id and interrupt use, odd word is map size
	always_comb begin
		entry   = dev_entry(slave_e'(dec_req_i.addr[3:1]));
		rd_data = '0;
		if ((dec_req_i.addr >> 4) == '0) begin
			if (dec_req_i.addr[0]) begin
				rd_data = entry.mapsz;
			end else begin
				rd_data = {entry.useintr, 15'b0, entry.id};
			end
		end else if (cmd_hit) begin
			rd_data = word_t'(rst_cmd_o);
		end
	end

	// Table and invalid device both answer during the decoded cycle
	always_comb begin
		tbl_rsp_o.rdy  = (dec_req_i.op != NONE) && (dec_slave_i inside {DEVTBL, INVALID});
		tbl_rsp_o.data = (dec_slave_i == DEVTBL) ? rd_data : '0;
	end

	// Command bits clear when the system reset they cause comes back
	always_ff @(posedge clk24mhz) begin
		if (rst_i) begin
			rst_cmd_o <= '0;
		end else if (cmd_wr) begin
			rst_cmd_o <= rst_cmd_t'(dec_req_i.data[1:0]);
		end
	end

endmodule

/* rtl/map_pkg.sv */
package map_pkg;

	typedef logic [15:0] dev_id_t;
	typedef logic [31:0] mapsz_t;

	// Slaves in address order, INVALID catches everything above BOOTLDR
	typedef enum logic [2:0] {
		SDCARD,
		DEVTBL,
		INTCTRL,
		SERIAL,
		RAM,
		RAMCTRL,
		BOOTLDR,
		INVALID
	} slave_e;

	localparam int unsigned NUM_SLAVES = 8;

	// Region sizes in bytes, indexed by slave_e
	localparam mapsz_t SLAVE_MAPSZ [NUM_SLAVES] = '{
		32'h0000_1000, 32'h0000_1000, 32'h0000_1000, 32'h0000_1000,
		32'h2000_0000, 32'h0001_0000, 32'h0000_1000, 32'h0000_1000
	};

	localparam dev_id_t SLAVE_ID [NUM_SLAVES] = '{4, 7, 3, 5, 1, 0, 0, 0};

	localparam logic SLAVE_USEINTR [NUM_SLAVES] = '{1, 0, 0, 1, 0, 0, 0, 0};

	// One line of the device table
	typedef struct packed {
		dev_id_t id;
		logic    useintr;
		mapsz_t  mapsz;
	} dev_entry_t;

	// Reset command bits as written by software
	typedef struct packed {
		logic rst1;
		logic rst0;
	} rst_cmd_t;

	function automatic dev_entry_t dev_entry(slave_e s);
		dev_entry_t e;
		e.id      = SLAVE_ID[s];
		e.useintr = SLAVE_USEINTR[s];
		e.mapsz   = SLAVE_MAPSZ[s];
		return e;
	endfunction

	// Byte base of a region, the sum of all regions below it
	function automatic mapsz_t region_base(slave_e s);
		mapsz_t base;
		base = '0;
		for (int k = 0; k < NUM_SLAVES; k++) begin
			if (k < int'(s)) begin
				base = base + SLAVE_MAPSZ[k];
			end
		end
		return base;
	endfunction

endpackage

/* rtl/rst_seq.sv */
`timescale 1ns/1ps
`include "sysctl_settings.svh"

module rst_seq (
	input  logic              clk24mhz,
	input  logic              rst_p,
	input  map_pkg::rst_cmd_t rst_cmd_i,
	output logic              sys_rst_o,
	output logic              pwroff_o
);

	typedef logic [`SYSCTL_RST_CNTR_BITSZ-1:0] rst_cntr_t;

	rst_cntr_t rst_cntr;
	logic      sw_warm;
	logic      sw_cold;
	logic      sw_pwroff;

	// rst1 alone is warm, both bits cold, rst0 alone power-off
	assign sw_warm   = rst_cmd_i.rst1 && !rst_cmd_i.rst0;
	assign sw_cold   = rst_cmd_i.rst1 && rst_cmd_i.rst0;
	assign sw_pwroff = !rst_cmd_i.rst1 && rst_cmd_i.rst0;

	always_ff @(posedge clk24mhz) begin
		if (rst_p || sw_warm || sw_cold) begin
			rst_cntr <= rst_cntr_t'(`SYSCTL_RST_CYCLES);
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off stays latched until the user reset or a cold reset
	always_ff @(posedge clk24mhz) begin
		if (rst_p || sw_cold) begin
			pwroff_o <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_o <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr != '0) || pwroff_o;

	// The system reset clears the command bits that caused it
	a_rst_clears_cmd: assert property (
		@(posedge clk24mhz) disable iff (rst_p)
		sys_rst_o |=> (!rst_cmd_i.rst1 && !rst_cmd_i.rst0)
	);

endmodule

/* rtl/sysctl_settings.svh */
`ifndef SYSCTL_SETTINGS_SVH
`define SYSCTL_SETTINGS_SVH

// Width of one bus data word
`define SYSCTL_ARCHBITSZ 32

// Byte address bits dropped to form a word address
`define SYSCTL_WORDSHIFT 2

// Word address width
`define SYSCTL_ADDRBITSZ (`SYSCTL_ARCHBITSZ - `SYSCTL_WORDSHIFT)

// One byte enable per data byte
`define SYSCTL_SELBITSZ (`SYSCTL_ARCHBITSZ / 8)

// Reset counter width and the count it reloads with
`define SYSCTL_RST_CNTR_BITSZ 16
`define SYSCTL_RST_CYCLES 32

// Word offset of the reset command register in the device table region
`define SYSCTL_RSTCMD_WORD 'h100

`endif

/* rtl/sysctl_top.sv */
`timescale 1ns/1ps

module sysctl_top (
	input  logic              clk24mhz,
	input  logic              rst_p,
	input  bus_pkg::bus_req_t req_i,
	input  bus_pkg::sel_t     sel_i,
	input  bus_pkg::bus_rsp_t ext_rsp_i,
	output bus_pkg::bus_rsp_t rsp_o,
	output bus_pkg::bus_req_t ext_req_o,
	output map_pkg::slave_e   ext_slave_o,
	output logic              sys_rst_o,
	output logic              pwroff_o
);
	import bus_pkg::*;
	import map_pkg::*;

	bus_req_t dec_req;
	slave_e   dec_slave;
	bus_rsp_t tbl_rsp;
	rst_cmd_t rst_cmd;
	logic     done;

	// The system reset also clears the bus side, including the command bits
	bus_decode u_bus_decode (
		.clk24mhz    (clk24mhz),
		.rst_i       (sys_rst_o),
		.req_i       (req_i),
		.done_i      (done),
		.dec_req_o   (dec_req),
		.dec_slave_o (dec_slave),
		.busy_o      ()
	);

	devtbl_exec u_devtbl_exec (
		.clk24mhz    (clk24mhz),
		.rst_i       (sys_rst_o),
		.dec_req_i   (dec_req),
		.dec_slave_i (dec_slave),
		.sel_i       (sel_i),
		.tbl_rsp_o   (tbl_rsp),
		.rst_cmd_o   (rst_cmd)
	);

	rst_seq u_rst_seq (
		.clk24mhz  (clk24mhz),
		.rst_p     (rst_p),
		.rst_cmd_i (rst_cmd),
		.sys_rst_o (sys_rst_o),
		.pwroff_o  (pwroff_o)
	);

	bus_result u_bus_result (
		.clk24mhz    (clk24mhz),
		.rst_i       (sys_rst_o),
		.dec_req_i   (dec_req),
		.dec_slave_i (dec_slave),
		.tbl_rsp_i   (tbl_rsp),
		.ext_rsp_i   (ext_rsp_i),
		.ext_req_o   (ext_req_o),
		.ext_slave_o (ext_slave_o),
		.rsp_o       (rsp_o),
		.done_o      (done)
	);

endmodule

/* sim/sysctl_tb.sv */
`timescale 1ns/1ps
`include "sysctl_settings.svh"

module sysctl_tb;
	import bus_pkg::*;
	import map_pkg::*;

	// What happens after the access, besides its response
	typedef enum logic [1:0] {
		P_NONE,
		P_RESET,
		P_PWROFF
	} post_e;

	typedef struct packed {
		bus_op_e     op;
		logic [31:0] addr;
		word_t       data;
		word_t       exp_data;
		slave_e      exp_slave;
		post_e       post;
	} entry_t;

	localparam int RST_WAIT = `SYSCTL_RST_CYCLES + 8;

	logic     clk24mhz;
	logic     rst_p;
	bus_req_t req_i;
	sel_t     sel_i;
	bus_rsp_t ext_rsp_i;
	bus_rsp_t rsp_o;
	bus_req_t ext_req_o;
	slave_e   ext_slave_o;
	logic     sys_rst_o;
	logic     pwroff_o;

	entry_t      tbl [$];
	int          errors = 0;
	int          passed = 0;
	int          failed = 0;
	int          cyc = 0;
	logic [31:0] rng_state = 32'hec65_b18e;

	// Seen by the external slave model
	int      ext_count = 0;
	int      reply_cyc = 0;
	slave_e  seen_slave;
	bus_op_e seen_op;
	waddr_t  seen_addr;
	word_t   seen_data;

	sysctl_top dut (
		.clk24mhz    (clk24mhz),
		.rst_p       (rst_p),
		.req_i       (req_i),
		.sel_i       (sel_i),
		.ext_rsp_i   (ext_rsp_i),
		.rsp_o       (rsp_o),
		.ext_req_o   (ext_req_o),
		.ext_slave_o (ext_slave_o),
		.sys_rst_o   (sys_rst_o),
		.pwroff_o    (pwroff_o)
	);

	initial begin
		clk24mhz = 1'b0;
		forever #10 clk24mhz = ~clk24mhz;
	end

	always @(posedge clk24mhz) cyc <= cyc + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Word offset inside the region, bases follow the reference map
	function automatic waddr_t word_offset(input logic [31:0] addr, input slave_e s);
		logic [31:0] base;
		case (s)
			INTCTRL: base = 32'h0000_2000;
			SERIAL:  base = 32'h0000_3000;
			RAM:     base = 32'h0000_4000;
			RAMCTRL: base = 32'h2000_4000;
			BOOTLDR: base = 32'h2001_4000;
			default: base = 32'h0;
		endcase
		return waddr_t'((addr - base) >> 2);
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_quiet();
		check_val("rsp_o.rdy", rsp_o.rdy, 0);
		check_val("ext_req_o.op", ext_req_o.op, NONE);
	endtask

	// Called at a negedge, returns there with the number of clock edges waited
	task automatic wait_rst_level(input logic level, input int max_cycles, output int n);
		n = 0;
		while (sys_rst_o !== level && n < max_cycles) begin
			@(posedge clk24mhz);
			n++;
			@(negedge clk24mhz);
			check_quiet();
		end
	endtask

	task automatic release_user_reset();
		int n;
		repeat (2) @(posedge clk24mhz);
		rst_p <= 1'b0;
		@(negedge clk24mhz);
		wait_rst_level(1'b0, RST_WAIT, n);
		check_val("reset cycles", n, `SYSCTL_RST_CYCLES);
		repeat (4) begin
			@(negedge clk24mhz);
			check_quiet();
		end
	endtask

	task automatic add_entry(input bus_op_e op, input logic [31:0] addr, input word_t data,
		input word_t exp_data, input slave_e s, input post_e p);
		tbl.push_back({op, addr, data, exp_data, s, p});
	endtask

	task automatic run_entry(input entry_t e, input int idx);
		int   lat;
		int   ext_before;
		logic got;
		@(posedge clk24mhz);
		req_i <= {e.op, e.addr[31:2], e.data};
		sel_i <= 4'hf;
		ext_before = ext_count;
		lat = 0;
		got = 1'b0;
		while (!got && lat < 20) begin
			@(posedge clk24mhz);
			lat++;
			req_i <= '0;
			sel_i <= '0;
			@(negedge clk24mhz);
			got = rsp_o.rdy;
		end
		assert (got) else begin
			$display("access %0d got no response within 20 cycles", idx);
			errors++;
		end
		if (e.op != WRITE) begin
			check_val("rsp_o.data", rsp_o.data, e.exp_data);
		end
		if (e.exp_slave == DEVTBL || e.exp_slave == INVALID) begin
			check_val("latency", lat, 2);
			check_val("ext_req_o count", ext_count - ext_before, 0);
		end else begin
			check_val("ext_req_o count", ext_count - ext_before, 1);
			check_val("ext_slave_o", seen_slave, e.exp_slave);
			check_val("ext_req_o.op", seen_op, e.op);
			check_val("ext_req_o.addr", seen_addr, word_offset(e.addr, e.exp_slave));
			check_val("ext_req_o.data", seen_data, e.data);
			check_val("rsp_o delay", cyc - reply_cyc, 1);
		end
	endtask

	task automatic run_post(input post_e p);
		int n;
		if (p == P_RESET) begin
			wait_rst_level(1'b1, 4, n);
			check_val("sys_rst_o", sys_rst_o, 1);
			wait_rst_level(1'b0, RST_WAIT, n);
			check_val("sys_rst_o", sys_rst_o, 0);
			check_val("pwroff_o", pwroff_o, 0);
		end else if (p == P_PWROFF) begin
			wait_rst_level(1'b1, 4, n);
			// Latch must outlast a full reset count
			repeat (RST_WAIT) @(negedge clk24mhz);
			check_val("pwroff_o", pwroff_o, 1);
			check_val("sys_rst_o", sys_rst_o, 1);
			@(posedge clk24mhz);
			rst_p <= 1'b1;
			release_user_reset();
			check_val("pwroff_o", pwroff_o, 0);
		end
	endtask

	task automatic report_test(input int idx, input string what, input int errs_before);
		if (errors == errs_before) begin
			passed++;
			$display("test %0d %s ok", idx, what);
		end else begin
			failed++;
			$display("test %0d %s failed", idx, what);
		end
	endtask

	// External slave, answers after 0 to 3 cycles
	initial begin : ext_slave_model
		int      delay;
		word_t   rsp_data;
		forever begin
			@(negedge clk24mhz);
			if (ext_req_o.op != NONE) begin
				ext_count++;
				seen_op = ext_req_o.op;
				seen_slave = ext_slave_o;
				seen_addr = ext_req_o.addr;
				seen_data = ext_req_o.data;
				rsp_data = {2'b00, ext_req_o.addr} ^ {ext_slave_o, 29'b0};
				if (seen_op == WRITE) begin
					rsp_data = '0;
				end
				rng_state = xorshift32(rng_state);
				delay = int'(rng_state[1:0]);
				@(posedge clk24mhz);
				repeat (delay) @(posedge clk24mhz);
				ext_rsp_i <= {rsp_data, 1'b1};
				@(negedge clk24mhz);
				reply_cyc = cyc;
				@(posedge clk24mhz);
				ext_rsp_i <= '0;
			end
		end
	end

	initial begin : watchdog
		int limit;
		#1;
		limit = 20 * tbl.size() + 5 * (`SYSCTL_RST_CYCLES + 10);
		repeat (limit) @(posedge clk24mhz);
		$display("watchdog expired after %0d cycles", limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin : main
		int errs_before;
		rst_p = 1'b1;
		req_i = '0;
		sel_i = '0;
		ext_rsp_i = '0;

		// Device table, id word then size word of every slave
		add_entry(READ, 32'h0000_1000, '0, 32'h8000_0004, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_1004, '0, 32'h0000_1000, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_1008, '0, 32'h0000_0007, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_100c, '0, 32'h0000_1000, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_1010, '0, 32'h0000_0003, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_1014, '0, 32'h0000_1000, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_1018, '0, 32'h8000_0005, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_101c, '0, 32'h0000_1000, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_1020, '0, 32'h0000_0001, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_1024, '0, 32'h2000_0000, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_1028, '0, 32'h0000_0000, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_102c, '0, 32'h0001_0000, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_1030, '0, 32'h0000_0000, DEVTBL, P_NONE);
		add_entry(READ, 32'h0000_1034, '0, 32'h0000_1000, DEVTBL, P_NONE);
		// External regions, data is offset xor slave index in the top bits
		add_entry(READ, 32'h0000_0124, '0, 32'h0000_0049, SDCARD, P_NONE);
		add_entry(READ, 32'h0000_2ff8, '0, 32'h4000_03fe, INTCTRL, P_NONE);
		add_entry(WRITE, 32'h0000_3010, 32'h5a5a_0001, '0, SERIAL, P_NONE);
		add_entry(READ, 32'h0000_3ffc, '0, 32'h6000_03ff, SERIAL, P_NONE);
		add_entry(READ, 32'h1234_5678, '0, 32'h848d_059e, RAM, P_NONE);
		add_entry(READ, 32'h2000_3ffc, '0, 32'h87ff_ffff, RAM, P_NONE);
		add_entry(READ, 32'h2000_4010, '0, 32'ha000_0004, RAMCTRL, P_NONE);
		add_entry(SWAP, 32'h2001_4ffc, 32'h0000_1234, 32'hc000_03ff, BOOTLDR, P_NONE);
		// Above BOOTLDR
		add_entry(READ, 32'h2001_5000, '0, 32'h0, INVALID, P_NONE);
		add_entry(WRITE, 32'h2001_6000, 32'hdead_beef, '0, INVALID, P_NONE);
		add_entry(READ, 32'h2001_6000, '0, 32'h0, INVALID, P_NONE);
		add_entry(READ, 32'hffff_fffc, '0, 32'h0, INVALID, P_NONE);
		// Reset command word
		add_entry(WRITE, 32'h0000_1400, 32'h2, '0, DEVTBL, P_RESET);
		add_entry(READ, 32'h0000_1400, '0, 32'h0, DEVTBL, P_NONE);
		add_entry(WRITE, 32'h0000_1400, 32'h1, '0, DEVTBL, P_PWROFF);
		add_entry(WRITE, 32'h0000_1400, 32'h3, '0, DEVTBL, P_RESET);
		add_entry(READ, 32'h0000_1400, '0, 32'h0, DEVTBL, P_NONE);

		errs_before = errors;
		release_user_reset();
		report_test(0, "user reset", errs_before);
		for (int i = 0; i < tbl.size(); i++) begin
			errs_before = errors;
			run_entry(tbl[i], i + 1);
			run_post(tbl[i].post);
			report_test(i + 1, $sformatf("op %0d addr %h", tbl[i].op, tbl[i].addr), errs_before);
		end

		$display("tests %0d passed %0d failed %0d errors %0d",
			passed + failed, passed, failed, errors);
		if (failed == 0 && errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* sysctl_top.f */
+incdir+rtl
rtl/bus_pkg.sv
rtl/map_pkg.sv
rtl/bus_decode.sv
rtl/devtbl_exec.sv
rtl/rst_seq.sv
rtl/bus_result.sv
rtl/sysctl_top.sv
sim/sysctl_tb.sv
